// File: hw/idc_pkg.sv
package idc_pkg;

    // Bus geometry
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 16;
    localparam int REG_IDX_W = 4;

    // Register index taken from byte address bits 5 to 2
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Register map
    localparam reg_idx_t IDX_DEVICE   = 4'd0;
    localparam reg_idx_t IDX_VERSION  = 4'd1;
    localparam reg_idx_t IDX_INT_SR   = 4'd2;
    localparam reg_idx_t IDX_INT_MASK = 4'd3;
    localparam reg_idx_t IDX_LED      = 4'd6;
    localparam reg_idx_t IDX_CLKSEL   = 4'd7;
    localparam reg_idx_t IDX_SPISS    = 4'd9;

    // LED geometry and register layout
    localparam int NUM_LEDS     = 12;
    localparam int NUM_LED_PINS = 4;
    localparam int LED_OVR_LSB  = 16;
    localparam int FP_LED_BIT   = 12;

    // Pin drive for one lit LED
    typedef struct packed {
        logic [NUM_LED_PINS-1:0] value;
        logic [NUM_LED_PINS-1:0] enable;
    } led_pattern_t;

    // Lower pin high for LEDs 0 to 5, reversed for 6 to 11
    localparam led_pattern_t LED_PATTERNS [NUM_LEDS] = '{
        '{value: 4'b0001, enable: 4'b0011},
        '{value: 4'b0001, enable: 4'b0101},
        '{value: 4'b0010, enable: 4'b0110},
        '{value: 4'b0100, enable: 4'b1100},
        '{value: 4'b0010, enable: 4'b1010},
        '{value: 4'b0001, enable: 4'b1001},
        '{value: 4'b0010, enable: 4'b0011},
        '{value: 4'b0100, enable: 4'b0101},
        '{value: 4'b0100, enable: 4'b0110},
        '{value: 4'b1000, enable: 4'b1100},
        '{value: 4'b1000, enable: 4'b1010},
        '{value: 4'b1000, enable: 4'b1001}
    };

endpackage

// File: hw/idc_reg_bus_if.sv
`timescale 1ns/1ps

// Decoded register access between the Wishbone port and the register bank
interface idc_reg_bus_if import idc_pkg::*; ();

    // Single write event of a transfer
    logic                 wr_stb;
    // Register index from address bits 5:2
    reg_idx_t             idx;
    logic [WB_DATA_W-1:0] wdata;
    // Address inside the 0x00-0x3F window
    logic                 sel_valid;
    // Read data for the current index
    logic [WB_DATA_W-1:0] rdata;

    modport port (
        output wr_stb, idx, wdata, sel_valid,
        input  rdata
    );

    modport target (
        input  wr_stb, idx, wdata, sel_valid,
        output rdata
    );

endinterface

// File: hw/idc_wb_port.sv
`timescale 1ns/1ps

module idc_wb_port import idc_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    idc_reg_bus_if.port          bus
);

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    logic ack_q;

    // Ack one edge after cyc and stb, held while both stay up
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i && wb_stb_i;
        end
    end

    // Master may abort the cycle at any time
    assign wb_ack_o = ack_q && wb_cyc_i;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Word index within the register window
    assign bus.idx       = wb_adr_i[5:2];
    // Upper address bits must be clear
    assign bus.sel_valid = (wb_adr_i[WB_ADDR_W-1:6] == '0);
    assign bus.wdata     = wb_dat_i;

    // Writes land on the ack cycle only
    assign bus.wr_stb = wb_ack_o && wb_we_i;

    // Read data straight from the bank while the cycle is open
    // Outside the window reads as zero
    assign wb_dat_o = (wb_cyc_i && bus.sel_valid) ? bus.rdata : '0;

endmodule

// File: hw/idc_reg_bank.sv
`timescale 1ns/1ps

module idc_reg_bank import idc_pkg::*; #(
    parameter logic [WB_DATA_W-1:0] DEVICE_ID  = "S5A7",
    parameter logic [WB_DATA_W-1:0] FW_VERSION = 32'h0000_0000
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    idc_reg_bus_if.target        bus,
    input  logic [WB_DATA_W-1:0] interrupt_i,
    input  logic [WB_DATA_W-1:0] led_value_i,
    output logic                 pci_interrupt_o,
    output logic                 sst_sel_o,
    output logic                 sst_sel_oe_o,
    output logic                 local_osc_en_o,
    output logic                 cs_b_o
);

    ////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////

    logic                 wr_hit;
    logic                 wr_int_sr;
    logic                 wr_int_mask;
    logic                 wr_clksel;
    logic                 wr_spiss;

    logic [WB_DATA_W-1:0] int_sr_q;
    logic [WB_DATA_W-1:0] int_mask_q;
    logic [WB_DATA_W-1:0] clksel_q;
    logic [WB_DATA_W-1:0] spiss_q;

    // Write strobe only counts inside the window
    assign wr_hit      = bus.wr_stb && bus.sel_valid;
    assign wr_int_sr   = wr_hit && (bus.idx == IDX_INT_SR);
    assign wr_int_mask = wr_hit && (bus.idx == IDX_INT_MASK);
    assign wr_clksel   = wr_hit && (bus.idx == IDX_CLKSEL);
    assign wr_spiss    = wr_hit && (bus.idx == IDX_SPISS);

    ////////////////////////////////////////////////////////////
    // Interrupts
    ////////////////////////////////////////////////////////////

    // Status tracks the inputs every cycle
    // A write clears the bits set in the write data
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            int_sr_q <= '0;
        end else if (wr_int_sr) begin
            int_sr_q <= int_sr_q & ~bus.wdata;
        end else begin
            int_sr_q <= interrupt_i;
        end
    end

    // Mask bit set means source is blocked
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            int_mask_q <= '0;
        end else if (wr_int_mask) begin
            int_mask_q <= bus.wdata;
        end
    end

    assign pci_interrupt_o = |(int_sr_q & ~int_mask_q);

    ////////////////////////////////////////////////////////////
    // Clock select and slave select
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            clksel_q <= '0;
            spiss_q  <= '0;
        end else begin
            if (wr_clksel) begin
                clksel_q <= bus.wdata;
            end
            if (wr_spiss) begin
                spiss_q <= bus.wdata;
            end
        end
    end

    // Bit 0 SST select, bit 1 its enable, bit 2 oscillator enable
    assign sst_sel_o      = clksel_q[0];
    assign sst_sel_oe_o   = clksel_q[1];
    assign local_osc_en_o = clksel_q[2];
    // Chip select is active low
    assign cs_b_o         = ~spiss_q[0];

    ////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (bus.idx)
            IDX_DEVICE:   bus.rdata = DEVICE_ID;
            IDX_VERSION:  bus.rdata = FW_VERSION;
            IDX_INT_SR:   bus.rdata = int_sr_q;
            IDX_INT_MASK: bus.rdata = int_mask_q;
            IDX_LED:      bus.rdata = led_value_i;
            IDX_CLKSEL:   bus.rdata = clksel_q;
            IDX_SPISS:    bus.rdata = spiss_q;
            // Reserved slots
            default:      bus.rdata = '0;
        endcase
    end

endmodule

// File: hw/idc_led_reg.sv
`timescale 1ns/1ps

module idc_led_reg import idc_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wr_stb_i,
    input  logic [WB_DATA_W-1:0] wdata_i,
    input  logic [NUM_LEDS-1:0]  internal_led_i,
    output logic [WB_DATA_W-1:0] led_value_o
);

    logic [WB_DATA_W-1:0] led_q;
    logic [NUM_LEDS-1:0]  ovr_wr;
    logic [NUM_LEDS-1:0]  ovr_q;

    // Override field from the incoming write
    assign ovr_wr = wdata_i[LED_OVR_LSB +: NUM_LEDS];
    // Override field as currently stored
    assign ovr_q  = led_q[LED_OVR_LSB +: NUM_LEDS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_q <= '0;
        end else if (wr_stb_i) begin
            // Upper bits incl. front panel LED and override field
            led_q[WB_DATA_W-1:NUM_LEDS] <= wdata_i[WB_DATA_W-1:NUM_LEDS];
            // Overridden LEDs take software value, others the live source
            led_q[NUM_LEDS-1:0] <= (wdata_i[NUM_LEDS-1:0] & ovr_wr) |
                                   (internal_led_i & ~ovr_wr);
        end else begin
            // Sticky capture of internal flashes
            // Cleared only by a rewrite
            led_q[NUM_LEDS-1:0] <= led_q[NUM_LEDS-1:0] | (internal_led_i & ~ovr_q);
        end
    end

    assign led_value_o = led_q;

endmodule

// File: hw/idc_led_charlieplex.sv
`timescale 1ns/1ps

module idc_led_charlieplex import idc_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [NUM_LEDS-1:0]     led_on_i,
    output logic [NUM_LED_PINS-1:0] led_pin_o,
    output logic [NUM_LED_PINS-1:0] led_pin_oe_o
);

    localparam int STEP_W = $clog2(NUM_LEDS);

    ////////////////////////////////////////////////////////////
    // Scan step
    ////////////////////////////////////////////////////////////

    logic [STEP_W-1:0] step_q;
    logic              step_wrap;

    // Last LED slot
    assign step_wrap = (step_q == STEP_W'(NUM_LEDS - 1));

    // One LED slot per cycle, modulo NUM_LEDS
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            step_q <= '0;
        end else if (step_wrap) begin
            step_q <= '0;
        end else begin
            step_q <= step_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pin drive
    ////////////////////////////////////////////////////////////

    led_pattern_t      step_pat;
    logic              step_lit;

    // Table lookup for the current slot
    assign step_pat = LED_PATTERNS[step_q];
    assign step_lit = led_on_i[step_q];

    // Registered pin state
    // Released pins float so the dark LEDs stay off
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_pin_o    <= '0;
            led_pin_oe_o <= '0;
        end else if (step_lit) begin
            // Exactly two pins driven, one high and one low
            led_pin_o    <= step_pat.value;
            led_pin_oe_o <= step_pat.enable;
        end else begin
            // Slot dark
            led_pin_oe_o <= '0;
        end
    end

endmodule

// File: hw/surf_id_ctrl.sv
`timescale 1ns/1ps

module surf_id_ctrl import idc_pkg::*; #(
    parameter logic [WB_DATA_W-1:0] DEVICE_ID  = "S5A7",
    parameter logic [WB_DATA_W-1:0] FW_VERSION = 32'h0000_0000
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    // Wishbone slave
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [WB_ADDR_W-1:0]    wb_adr_i,
    input  logic [WB_DATA_W-1:0]    wb_dat_i,
    output logic [WB_DATA_W-1:0]    wb_dat_o,
    output logic                    wb_ack_o,
    // Interrupts
    input  logic [WB_DATA_W-1:0]    interrupt_i,
    output logic                    pci_interrupt_o,
    // LEDs
    input  logic [NUM_LEDS-1:0]     internal_led_i,
    output logic [NUM_LED_PINS-1:0] led_pin_o,
    output logic [NUM_LED_PINS-1:0] led_pin_oe_o,
    output logic                    fp_led_o,
    // Clocking and flash select
    output logic                    sst_sel_o,
    output logic                    sst_sel_oe_o,
    output logic                    local_osc_en_o,
    output logic                    cs_b_o
);

    idc_reg_bus_if reg_bus ();

    logic [WB_DATA_W-1:0] led_value;
    logic                 led_wr_stb;

    ////////////////////////////////////////////////////////////
    // Bus port and register bank
    ////////////////////////////////////////////////////////////

    idc_wb_port u_wb_port (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .bus      (reg_bus.port)
    );

    idc_reg_bank #(
        .DEVICE_ID  (DEVICE_ID),
        .FW_VERSION (FW_VERSION)
    ) u_reg_bank (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .bus             (reg_bus.target),
        .interrupt_i     (interrupt_i),
        .led_value_i     (led_value),
        .pci_interrupt_o (pci_interrupt_o),
        .sst_sel_o       (sst_sel_o),
        .sst_sel_oe_o    (sst_sel_oe_o),
        .local_osc_en_o  (local_osc_en_o),
        .cs_b_o          (cs_b_o)
    );

    ////////////////////////////////////////////////////////////
    // LED path
    ////////////////////////////////////////////////////////////

    // LED register write qualified here only
    assign led_wr_stb = reg_bus.wr_stb && reg_bus.sel_valid && (reg_bus.idx == IDX_LED);

    idc_led_reg u_led_reg (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wr_stb_i       (led_wr_stb),
        .wdata_i        (reg_bus.wdata),
        .internal_led_i (internal_led_i),
        .led_value_o    (led_value)
    );

    // Scan uses only the per-LED state bits
    idc_led_charlieplex u_led_charlieplex (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .led_on_i     (led_value[NUM_LEDS-1:0]),
        .led_pin_o    (led_pin_o),
        .led_pin_oe_o (led_pin_oe_o)
    );

    assign fp_led_o = led_value[FP_LED_BIT];

endmodule

// File: verification/idc_assertions.sv
`timescale 1ns/1ps

module idc_assertions import idc_pkg::*; (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    wb_cyc_i,
    input logic                    wb_stb_i,
    input logic                    wb_ack_o,
    input logic [NUM_LED_PINS-1:0] led_pin_oe_o
);

    // Ack only inside an open cycle
    assert property (@(posedge clk_i) disable iff (rst_i) wb_ack_o |-> wb_cyc_i)
        else $error("ack high without cyc");

    // Ack answers a request seen one edge earlier
    assert property (@(posedge clk_i) disable iff (rst_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else $error("ack without cyc and stb in the previous cycle");

    // Pins released, or one LED driven on exactly two pins
    assert property (@(posedge clk_i) disable iff (rst_i)
        (led_pin_oe_o == '0) || ($countones(led_pin_oe_o) == 2))
        else $error("LED pin enables not zero or two");

endmodule

////////////////////////////////////////////////////////////
// Attachment to the bus port and the LED scan
////////////////////////////////////////////////////////////

bind idc_wb_port idc_assertions u_bus_checks (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_o     (wb_ack_o),
    .led_pin_oe_o ('0)
);

bind idc_led_charlieplex idc_assertions u_pin_checks (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .wb_cyc_i     (1'b0),
    .wb_stb_i     (1'b0),
    .wb_ack_o     (1'b0),
    .led_pin_oe_o (led_pin_oe_o)
);

// File: verification/tb_surf_id_ctrl.sv
`timescale 1ns/1ps

module tb_surf_id_ctrl import idc_pkg::*; ();

    localparam int CLK_HALF       = 50;
    localparam int RST_CYCLES     = 16;
    localparam int CYCLES_PER_VEC = 40;

    logic                    clk_i;
    logic                    rst_i;
    logic                    wb_cyc_i;
    logic                    wb_stb_i;
    logic                    wb_we_i;
    logic [WB_ADDR_W-1:0]    wb_adr_i;
    logic [WB_DATA_W-1:0]    wb_dat_i;
    logic [WB_DATA_W-1:0]    wb_dat_o;
    logic                    wb_ack_o;
    logic [WB_DATA_W-1:0]    interrupt_i;
    logic                    pci_interrupt_o;
    logic [NUM_LEDS-1:0]     internal_led_i;
    logic [NUM_LED_PINS-1:0] led_pin_o;
    logic [NUM_LED_PINS-1:0] led_pin_oe_o;
    logic                    fp_led_o;
    logic                    sst_sel_o;
    logic                    sst_sel_oe_o;
    logic                    local_osc_en_o;
    logic                    cs_b_o;

    // Vector fields and run state
    logic [63:0]             v_op;
    logic [31:0]             v_addr;
    logic [31:0]             v_data;
    logic [31:0]             v_exp;
    logic [31:0]             v_mask;
    logic [8*160-1:0]        line;
    logic [31:0]             lfsr_state;
    int                      vec_count;

    surf_id_ctrl #(
        .DEVICE_ID  ("S5A7"),
        .FW_VERSION (32'h0000_0102)
    ) u_surf_id_ctrl (.*);

    always #(CLK_HALF) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // Reporting and reference models
    ////////////////////////////////////////////////////////////

    task automatic fail_and_stop();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s, got %h expected %h", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    // Pin pairs 0-1 0-2 1-2 2-3 1-3 0-3, lower pin high for LEDs 0 to 5
    function automatic logic [7:0] pin_pattern(input int led);
        logic [3:0] en;
        logic [3:0] lo_bit;
        case (led % 6)
            0:       en = 4'b0011;
            1:       en = 4'b0101;
            2:       en = 4'b0110;
            3:       en = 4'b1100;
            4:       en = 4'b1010;
            default: en = 4'b1001;
        endcase
        lo_bit = en & (~en + 4'd1);
        return {(led < 6) ? lo_bit : (en ^ lo_bit), en};
    endfunction

    // Fibonacci step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_random(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Packed view of the side-band outputs, layout as in the vector file
    function automatic logic [31:0] pin_state();
        return {20'b0, led_pin_oe_o, 1'b0, wb_ack_o, fp_led_o, pci_interrupt_o, cs_b_o,
                local_osc_en_o, sst_sel_oe_o, sst_sel_o};
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus master
    ////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        // Values seen at the edge are the ones held through the last cycle
        do @(posedge clk_i); while (wb_ack_o !== 1'b1);
        rd = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test steps
    ////////////////////////////////////////////////////////////

    task automatic irq_test(input logic [31:0] mask);
        logic [31:0] pattern;
        logic [31:0] rd;
        draw_random(pattern);
        @(posedge clk_i);
        interrupt_i <= pattern;
        bus_cycle(1'b1, 16'h000C, mask, rd);
        bus_cycle(1'b0, 16'h0008, '0, rd);
        check_value(rd, pattern, "interrupt status");
        bus_cycle(1'b0, 16'h000C, '0, rd);
        check_value(rd, mask, "interrupt mask");
        @(negedge clk_i);
        check_value(pci_interrupt_o, |(pattern & ~mask), "pci interrupt");
    endtask

    task automatic scan_test(input int cycles, input logic [NUM_LEDS-1:0] lit);
        logic [NUM_LEDS-1:0] seen;
        logic [NUM_LEDS-1:0] hits;
        seen = '0;
        // Pin stage lags the LED register by a cycle
        repeat (2) @(posedge clk_i);
        repeat (cycles) begin
            @(negedge clk_i);
            hits = '0;
            for (int k = 0; k < NUM_LEDS; k++) begin
                hits[k] = ({led_pin_o, led_pin_oe_o} == pin_pattern(k));
            end
            if (led_pin_oe_o != '0) begin
                check_value((hits & lit) != '0, 1, "scan shows a lit LED");
                seen = seen | (hits & lit);
            end
        end
        check_value(seen, lit, "scan coverage");
    endtask

    // One vector line, comment lines give fewer fields or a lone hash
    task automatic read_line(input int fd, output logic ok);
        int n;
        line = '0;
        n = $fgets(line, fd);
        if (n > 0) begin
            n = $sscanf(line, "%s %h %h %h %h", v_op, v_addr, v_data, v_exp, v_mask);
        end
        ok = (n == 5) && (v_op != "#");
    endtask

    task automatic run_vectors(input logic count_only);
        int          fd;
        logic        ok;
        logic [31:0] rd;
        fd = $fopen("verification/idc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            fail_and_stop();
        end
        while (!$feof(fd)) begin
            read_line(fd, ok);
            if (ok && count_only) begin
                vec_count++;
            end else if (ok) begin
                case (v_op)
                    "read": begin
                        bus_cycle(1'b0, v_addr[15:0], '0, rd);
                        check_value(rd & v_mask, v_exp & v_mask,
                                    $sformatf("read at %h", v_addr[15:0]));
                    end
                    "write": bus_cycle(1'b1, v_addr[15:0], v_data, rd);
                    "pins": begin
                        @(posedge clk_i);
                        if (v_addr == 0) begin
                            interrupt_i <= v_data;
                        end else begin
                            internal_led_i <= v_data[NUM_LEDS-1:0];
                        end
                    end
                    "outs": begin
                        @(negedge clk_i);
                        check_value(pin_state() & v_mask, v_exp & v_mask, "output pins");
                    end
                    "idle": repeat (v_data) @(posedge clk_i);
                    "irq":  irq_test(v_data);
                    "scan": scan_test(v_data, v_exp[NUM_LEDS-1:0]);
                    default: begin
                        $display("Unknown operation in the vector file");
                        fail_and_stop();
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = '0;
        wb_dat_i       = '0;
        interrupt_i    = '0;
        internal_led_i = '0;
        lfsr_state     = 32'd3;
        vec_count      = 0;
        run_vectors(1'b1);
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        run_vectors(1'b0);
        $display("All tests passed");
        $finish;
    end

    // Vector count is final once reset is released
    initial begin
        @(negedge rst_i);
        repeat (vec_count * CYCLES_PER_VEC) @(posedge clk_i);
        $display("Timeout: the vector run did not finish within %0d cycles",
                 vec_count * CYCLES_PER_VEC);
        fail_and_stop();
    end

endmodule

// File: compile.f
hw/idc_pkg.sv
hw/idc_reg_bus_if.sv
hw/idc_wb_port.sv
hw/idc_reg_bank.sv
hw/idc_led_reg.sv
hw/idc_led_charlieplex.sv
hw/surf_id_ctrl.sv
verification/idc_assertions.sv
verification/tb_surf_id_ctrl.sv

// File: verification/idc_vectors.txt
# Columns op addr data expect mask in hex, pins addr 0 drives interrupt_i and 1 internal_led_i
# Outs bits 11:8 led_pin_oe 6 ack 5 fp_led 4 pci_int 3 cs_b 2 osc_en 1 sst_oe 0 sst_sel
outs  0000 00000000 00000008 00000f7f
read  0000 00000000 53354137 ffffffff
read  0004 00000000 00000102 ffffffff
write 0000 00000000 00000000 00000000
read  0000 00000000 53354137 ffffffff
write 0014 ffffffff 00000000 00000000
read  0014 00000000 00000000 ffffffff
read  0040 00000000 00000000 ffffffff
write 005c 00000007 00000000 00000000
write 101c 00000007 00000000 00000000
outs  0000 00000000 00000008 0000000f
write 001c 00000005 00000000 00000000
read  001c 00000000 00000005 ffffffff
outs  0000 00000000 0000000d 0000000f
write 001c 00000002 00000000 00000000
outs  0000 00000000 0000000a 0000000f
write 0024 00000001 00000000 00000000
read  0024 00000000 00000001 ffffffff
outs  0000 00000000 00000002 0000000f
write 0024 00000000 00000000 00000000
outs  0000 00000000 0000000a 0000000f
irq   0000 00000000 00000000 00000000
irq   0000 ffffffff 00000000 00000000
irq   0000 0000ffff 00000000 00000000
irq   0000 ffff0000 00000000 00000000
irq   0000 55555555 00000000 00000000
pins  0000 00000000 00000000 00000000
idle  0000 00000002 00000000 00000000
read  0008 00000000 00000000 ffffffff
write 000c 00000000 00000000 00000000
outs  0000 00000000 00000000 00000010
write 0018 0fff10a5 00000000 00000000
read  0018 00000000 0fff10a5 ffffffff
outs  0000 00000000 00000020 00000020
scan  0000 00000024 000000a5 00000000
write 0018 0ff00000 00000000 00000000
read  0018 00000000 0ff00000 ffffffff
outs  0000 00000000 00000000 00000020
pins  0001 00000013 00000000 00000000
pins  0001 00000000 00000000 00000000
read  0018 00000000 0ff00003 ffffffff
idle  0000 00000005 00000000 00000000
read  0018 00000000 0ff00003 ffffffff
scan  0000 00000018 00000003 00000000
write 0018 0fff0000 00000000 00000000
scan  0000 00000018 00000000 00000000
write 0018 0fff0fff 00000000 00000000
scan  0000 00000018 00000fff 00000000
